//--- pkt_fmt_pkg.sv
package pkt_fmt_pkg;

	//////////////////////////////
	// Widths and offsets
	//////////////////////////////

	// Memory word and payload byte
	localparam int WORD_W = 32;
	localparam int BYTE_W = 8;

	// Header word to first payload word, CRC byte right after the last payload byte
	localparam int unsigned HDR_TO_PAYLOAD = 2;

	typedef logic [BYTE_W-1:0] byte_t;
	typedef logic [3:0]        ecc_t;
	typedef logic [3:0]        cnt_t;

	// CRC-8 generator x^8 + x^2 + x + 1
	localparam byte_t CRC_POLY = 8'h07;

	// Header word, last member sits at bit 0
	typedef struct packed {
		logic [15:0] upper;
		logic [2:0]  sop;
		logic        ecc_msb;
		logic [3:0]  pkt_type;
		cnt_t        byte_cnt;
		ecc_t        ecc;
	} hdr_t;

	//////////////////////////////
	// ECC and CRC steps
	//////////////////////////////

	// Hamming-style code over {pkt_type, byte_cnt}
	function automatic ecc_t ecc_code(byte_t d);
		ecc_t c;
		c[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6];
		c[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6];
		c[2] = d[1] ^ d[2] ^ d[3] ^ d[7];
		c[3] = d[4] ^ d[5] ^ d[6] ^ d[7];
		return c;
	endfunction

	// One byte into the running CRC, MSB first
	function automatic byte_t crc8_step(byte_t crc, byte_t d);
		byte_t c;
		c = crc ^ d;
		for (int i = 0; i < BYTE_W; i++) begin
			c = c[BYTE_W-1] ? ({c[BYTE_W-2:0], 1'b0} ^ CRC_POLY) : {c[BYTE_W-2:0], 1'b0};
		end
		return c;
	endfunction

endpackage

//--- chk_cfg_pkg.sv
package chk_cfg_pkg;

	//////////////////////////////
	// Packet memory
	//////////////////////////////

	localparam int MEM_DEPTH = 64;
	localparam int ADDR_W    = $clog2(MEM_DEPTH);

	typedef logic [ADDR_W-1:0] addr_t;

	//////////////////////////////
	// Read port arbitration
	//////////////////////////////

	// Lower index wins, so the parse checker sits at 0
	localparam int N_REQ = 2;
	localparam int REQ_W = (N_REQ > 1) ? $clog2(N_REQ) : 1;

	typedef logic [REQ_W-1:0] req_idx_t;

	localparam req_idx_t REQ_PARSE = req_idx_t'(0);
	localparam req_idx_t REQ_DI    = req_idx_t'(1);

	//////////////////////////////
	// Checker results
	//////////////////////////////

	// Parse check flags
	typedef struct packed {
		logic ecc_corr;
		logic ecc_uncorr;
		logic crc_err;
	} parse_res_t;

endpackage

//--- mem_rd_if.sv
`timescale 1ns/1ps

interface mem_rd_if import chk_cfg_pkg::*, pkt_fmt_pkg::*; ();

	// Request side
	logic              req;
	addr_t             addr;

	// Grant and return side
	logic              gnt;
	logic [WORD_W-1:0] rdata;
	logic              rvalid;

	// Checker holds req and addr until gnt, word comes back one cycle later
	modport requester (
		output req,
		output addr,
		input  gnt,
		input  rdata,
		input  rvalid
	);

	modport arbiter (
		input  req,
		input  addr,
		output gnt,
		output rdata,
		output rvalid
	);

endinterface

//--- pkt_mem.sv
`timescale 1ns/1ps

module pkt_mem import pkt_fmt_pkg::*, chk_cfg_pkg::*; (
	input  logic              clk,
	input  logic              reset,

	// Load port
	input  logic              we_i,
	input  addr_t             waddr_i,
	input  logic [WORD_W-1:0] wdata_i,

	// Arbitrated read port
	input  logic              re_i,
	input  addr_t             raddr_i,
	output logic [WORD_W-1:0] rdata_o
);

	logic [WORD_W-1:0] mem_array [MEM_DEPTH];

	// Write lands at the clock edge
	always_ff @(posedge clk) begin
		if (we_i) begin
			mem_array[waddr_i] <= wdata_i;
		end
	end

	// Registered read with the word one cycle after re_i
	always_ff @(posedge clk) begin
		if (re_i) begin
			rdata_o <= mem_array[raddr_i];
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	// Reads use a known address inside the array
	a_raddr_range: assert property (@(posedge clk) disable iff (reset)
		re_i |-> (!$isunknown(raddr_i) && (int'(raddr_i) <= MEM_DEPTH - 1)));

endmodule

//--- mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import pkt_fmt_pkg::*, chk_cfg_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	mem_rd_if.arbiter         parse_port,
	mem_rd_if.arbiter         di_port,
	output logic              mem_re_o,
	output addr_t             mem_raddr_o,
	input  logic [WORD_W-1:0] mem_rdata_i
);

	logic [N_REQ-1:0] req_vec;
	logic [N_REQ-1:0] gnt_vec;
	addr_t            addr_vec [N_REQ];
	req_idx_t         owner_s;

	// Owner of the read in flight
	req_idx_t         owner_reg;
	logic             pend_reg;

	// Gather requesters by index
	assign req_vec[REQ_PARSE]  = parse_port.req;
	assign req_vec[REQ_DI]     = di_port.req;
	assign addr_vec[REQ_PARSE] = parse_port.addr;
	assign addr_vec[REQ_DI]    = di_port.addr;

	// Fixed priority where the lowest set bit wins
	assign gnt_vec = req_vec & ~(req_vec - 1'b1);

	always_comb begin
		owner_s = REQ_PARSE;
		for (int i = 0; i < N_REQ; i++) begin
			if (gnt_vec[i])
				owner_s = req_idx_t'(i);
		end
	end

	assign parse_port.gnt = gnt_vec[REQ_PARSE];
	assign di_port.gnt    = gnt_vec[REQ_DI];

	// Memory side
	assign mem_re_o    = |gnt_vec;
	assign mem_raddr_o = addr_vec[owner_s];

	always_ff @(posedge clk) begin
		if (reset) begin
			pend_reg  <= 1'b0;
			owner_reg <= REQ_PARSE;
		end else begin
			pend_reg  <= |gnt_vec;
			owner_reg <= owner_s;
		end
	end

	// Word goes to everyone but only the owner sees rvalid
	assign parse_port.rdata  = mem_rdata_i;
	assign di_port.rdata     = mem_rdata_i;
	assign parse_port.rvalid = pend_reg && (owner_reg == REQ_PARSE);
	assign di_port.rvalid    = pend_reg && (owner_reg == REQ_DI);

	//////////////////////////////
	// Checks
	//////////////////////////////

	// A requester that loses keeps its request and address
	a_di_hold: assert property (@(posedge clk) disable iff (reset)
		di_port.req && !di_port.gnt |=> di_port.req && $stable(di_port.addr));

	// One read in flight per requester so req drops after its grant
	a_parse_one_read: assert property (@(posedge clk) disable iff (reset)
		parse_port.gnt |=> !parse_port.req);

	a_di_one_read: assert property (@(posedge clk) disable iff (reset)
		di_port.gnt |=> !di_port.req);

endmodule

//--- parse_checker.sv
`timescale 1ns/1ps

module parse_checker import pkt_fmt_pkg::*, chk_cfg_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        start_i,
	input  addr_t       hdr_addr_i,
	mem_rd_if.requester mem,
	output logic        done_o,
	output parse_res_t  res_o
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_HDR_RD,
		S_CRC_RD,
		S_COMPARE
	} state_t;

	// Control
	state_t     state_reg;
	logic       wait_reg;
	logic       done_reg;
	parse_res_t res_reg;

	// Datapath
	addr_t      addr_reg;
	cnt_t       cnt_reg;
	byte_t      crc_reg;

	hdr_t       hdr_s;
	ecc_t       syndrome_s;
	byte_t      rd_byte_s;

	//////////////////////////////
	// Header decode
	//////////////////////////////

	assign hdr_s     = hdr_t'(mem.rdata);
	assign rd_byte_s = mem.rdata[BYTE_W-1:0];

	// Received code against the one rebuilt from type and count
	assign syndrome_s = hdr_s.ecc ^ ecc_code({hdr_s.pkt_type, hdr_s.byte_cnt});

	// One read at a time, request drops while a word is on its way
	assign mem.req  = (state_reg != S_IDLE) && !wait_reg;
	assign mem.addr = addr_reg;

	//////////////////////////////
	// FSM
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state_reg <= S_IDLE;
			wait_reg  <= 1'b0;
			done_reg  <= 1'b0;
			res_reg   <= '0;
		end else begin
			done_reg <= 1'b0;
			if (mem.gnt)
				wait_reg <= 1'b1;
			else if (mem.rvalid)
				wait_reg <= 1'b0;

			case (state_reg)
				S_IDLE: begin
					// Flags from the last run stay until here
					if (start_i) begin
						res_reg   <= '0;
						state_reg <= S_HDR_RD;
					end
				end
				S_HDR_RD: begin
					if (mem.rvalid) begin
						// ECC MSB tells single from multi-bit error
						if (syndrome_s != '0) begin
							if (hdr_s.ecc_msb)
								res_reg.ecc_corr <= 1'b1;
							else
								res_reg.ecc_uncorr <= 1'b1;
						end
						// Count taken as is, even on a bad code
						state_reg <= (hdr_s.byte_cnt == '0) ? S_COMPARE : S_CRC_RD;
					end
				end
				S_CRC_RD: begin
					if (mem.rvalid && (cnt_reg == cnt_t'(1)))
						state_reg <= S_COMPARE;
				end
				S_COMPARE: begin
					// Stored CRC byte against the folded one
					if (mem.rvalid) begin
						res_reg.crc_err <= (rd_byte_s != crc_reg);
						done_reg        <= 1'b1;
						state_reg       <= S_IDLE;
					end
				end
				default: state_reg <= S_IDLE;
			endcase
		end
	end

	// Address walk and CRC fold
	always_ff @(posedge clk) begin
		if (state_reg == S_IDLE) begin
			addr_reg <= hdr_addr_i;
			crc_reg  <= '0;
		end else if (mem.rvalid) begin
			case (state_reg)
				S_HDR_RD: begin
					addr_reg <= addr_reg + addr_t'(HDR_TO_PAYLOAD);
					cnt_reg  <= hdr_s.byte_cnt;
				end
				S_CRC_RD: begin
					addr_reg <= addr_reg + addr_t'(1);
					cnt_reg  <= cnt_reg - cnt_t'(1);
					crc_reg  <= crc8_step(crc_reg, rd_byte_s);
				end
				default: ;
			endcase
		end
	end

	assign done_o = done_reg;
	assign res_o  = res_reg;

	// Done is a single-cycle pulse
	a_done_pulse: assert property (@(posedge clk) disable iff (reset)
		done_o |=> !done_o);

endmodule

//--- di_checker.sv
`timescale 1ns/1ps

module di_checker import pkt_fmt_pkg::*, chk_cfg_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        start_i,
	input  addr_t       addr_in_i,
	input  addr_t       addr_out_i,
	input  cnt_t        byte_cnt_i,
	mem_rd_if.requester mem,
	output logic        done_o,
	output logic        err_o
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_RD_IN,
		S_RD_OUT
	} state_t;

	// Control
	state_t state_reg;
	logic   wait_reg;
	logic   done_reg;
	logic   err_reg;

	// Datapath
	addr_t  in_base_reg;
	addr_t  out_base_reg;
	cnt_t   cnt_reg;
	cnt_t   idx_reg;
	byte_t  in_byte_reg;

	byte_t  rd_byte_s;
	logic   last_s;

	assign rd_byte_s = mem.rdata[BYTE_W-1:0];
	assign last_s    = (idx_reg == cnt_reg - cnt_t'(1));

	// Input byte k, then output payload byte k
	assign mem.req  = (state_reg != S_IDLE) && !wait_reg;
	assign mem.addr = ((state_reg == S_RD_OUT) ? out_base_reg : in_base_reg) + addr_t'(idx_reg);

	//////////////////////////////
	// FSM
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state_reg <= S_IDLE;
			wait_reg  <= 1'b0;
			done_reg  <= 1'b0;
			err_reg   <= 1'b0;
		end else begin
			done_reg <= 1'b0;
			if (mem.gnt)
				wait_reg <= 1'b1;
			else if (mem.rvalid)
				wait_reg <= 1'b0;

			case (state_reg)
				S_IDLE: begin
					if (start_i) begin
						err_reg <= 1'b0;
						// Empty compare ends at once, clean
						if (byte_cnt_i == '0)
							done_reg <= 1'b1;
						else
							state_reg <= S_RD_IN;
					end
				end
				S_RD_IN: begin
					if (mem.rvalid)
						state_reg <= S_RD_OUT;
				end
				S_RD_OUT: begin
					if (mem.rvalid) begin
						// Sticky mismatch
						if (rd_byte_s != in_byte_reg)
							err_reg <= 1'b1;
						if (last_s) begin
							done_reg  <= 1'b1;
							state_reg <= S_IDLE;
						end else begin
							state_reg <= S_RD_IN;
						end
					end
				end
				default: state_reg <= S_IDLE;
			endcase
		end
	end

	// Bases latched at start, index walks the payload
	always_ff @(posedge clk) begin
		if (state_reg == S_IDLE) begin
			in_base_reg  <= addr_in_i;
			out_base_reg <= addr_out_i + addr_t'(HDR_TO_PAYLOAD);
			cnt_reg      <= byte_cnt_i;
			idx_reg      <= '0;
		end else if (mem.rvalid) begin
			if (state_reg == S_RD_IN)
				in_byte_reg <= rd_byte_s;
			else
				idx_reg <= idx_reg + cnt_t'(1);
		end
	end

	assign done_o = done_reg;
	assign err_o  = err_reg;

endmodule

//--- pkt_check_top.sv
`timescale 1ns/1ps

module pkt_check_top import pkt_fmt_pkg::*, chk_cfg_pkg::*; (
	input  logic              clk,
	input  logic              reset,

	// Memory load port, only while both checks are idle
	input  logic              mem_we_i,
	input  addr_t             mem_addr_i,
	input  logic [WORD_W-1:0] mem_wdata_i,

	// Parse check
	input  logic              parse_start_i,
	input  addr_t             parse_addr_i,
	output logic              parse_done_o,
	output logic              ecc_corr_o,
	output logic              ecc_uncorr_o,
	output logic              crc_err_o,

	// Data-integrity check
	input  logic              di_start_i,
	input  addr_t             di_addr_in_i,
	input  addr_t             di_addr_out_i,
	input  cnt_t              di_byte_cnt_i,
	output logic              di_done_o,
	output logic              di_err_o
);

	logic              mem_re;
	addr_t             mem_raddr;
	logic [WORD_W-1:0] mem_rdata;
	parse_res_t        parse_res;

	// One read link per checker
	mem_rd_if parse_rd ();
	mem_rd_if di_rd ();

	//////////////////////////////
	// Memory and arbiter
	//////////////////////////////

	pkt_mem u_pkt_mem (
		.clk     (clk),
		.reset   (reset),
		.we_i    (mem_we_i),
		.waddr_i (mem_addr_i),
		.wdata_i (mem_wdata_i),
		.re_i    (mem_re),
		.raddr_i (mem_raddr),
		.rdata_o (mem_rdata)
	);

	mem_arbiter u_mem_arbiter (
		.clk         (clk),
		.reset       (reset),
		.parse_port  (parse_rd.arbiter),
		.di_port     (di_rd.arbiter),
		.mem_re_o    (mem_re),
		.mem_raddr_o (mem_raddr),
		.mem_rdata_i (mem_rdata)
	);

	//////////////////////////////
	// Checkers
	//////////////////////////////

	parse_checker u_parse_checker (
		.clk        (clk),
		.reset      (reset),
		.start_i    (parse_start_i),
		.hdr_addr_i (parse_addr_i),
		.mem        (parse_rd.requester),
		.done_o     (parse_done_o),
		.res_o      (parse_res)
	);

	di_checker u_di_checker (
		.clk        (clk),
		.reset      (reset),
		.start_i    (di_start_i),
		.addr_in_i  (di_addr_in_i),
		.addr_out_i (di_addr_out_i),
		.byte_cnt_i (di_byte_cnt_i),
		.mem        (di_rd.requester),
		.done_o     (di_done_o),
		.err_o      (di_err_o)
	);

	// Flag ports
	assign ecc_corr_o   = parse_res.ecc_corr;
	assign ecc_uncorr_o = parse_res.ecc_uncorr;
	assign crc_err_o    = parse_res.crc_err;

endmodule

//--- tb_pkt_check.sv
`timescale 1ns/1ps

module tb_pkt_check import pkt_fmt_pkg::*, chk_cfg_pkg::*; ();

	// Clock, reset and run limits
	localparam real CLK_PERIOD  = 8.0;
	localparam int  RST_CYCLES  = 8;
	localparam int  MAX_CNT     = 15;
	// Longest check while the other checker contends
	localparam int  TEST_CYCLES = 4 * (2 * MAX_CNT + 4);
	localparam int  MAX_REC     = 64;
	localparam int  NAME_W      = 8 * 16;

	logic              clk = 1'b0;
	logic              reset;

	// DUT ports
	logic              mem_we_i;
	addr_t             mem_addr_i;
	logic [WORD_W-1:0] mem_wdata_i;
	logic              parse_start_i;
	addr_t             parse_addr_i;
	logic              parse_done_o;
	logic              ecc_corr_o;
	logic              ecc_uncorr_o;
	logic              crc_err_o;
	logic              di_start_i;
	addr_t             di_addr_in_i;
	addr_t             di_addr_out_i;
	cnt_t              di_byte_cnt_i;
	logic              di_done_o;
	logic              di_err_o;

	// Memory image from the stim file
	addr_t             load_addr [MAX_REC];
	logic [WORD_W-1:0] load_data [MAX_REC];

	// Test records
	logic [NAME_W-1:0] t_name [MAX_REC];
	logic [7:0]        t_kind [MAX_REC];
	addr_t             t_paddr [MAX_REC];
	addr_t             t_din [MAX_REC];
	addr_t             t_dout [MAX_REC];
	cnt_t              t_cnt [MAX_REC];
	parse_res_t        t_exp_parse [MAX_REC];
	logic              t_exp_di [MAX_REC];

	int                n_loads;
	int                n_tests;
	int                n_pass;
	int                n_fail;
	int                cycles = 0;
	int                cycle_limit = 0;
	logic              test_err;

	pkt_check_top u_pkt_check_top (
		.clk           (clk),
		.reset         (reset),
		.mem_we_i      (mem_we_i),
		.mem_addr_i    (mem_addr_i),
		.mem_wdata_i   (mem_wdata_i),
		.parse_start_i (parse_start_i),
		.parse_addr_i  (parse_addr_i),
		.parse_done_o  (parse_done_o),
		.ecc_corr_o    (ecc_corr_o),
		.ecc_uncorr_o  (ecc_uncorr_o),
		.crc_err_o     (crc_err_o),
		.di_start_i    (di_start_i),
		.di_addr_in_i  (di_addr_in_i),
		.di_addr_out_i (di_addr_out_i),
		.di_byte_cnt_i (di_byte_cnt_i),
		.di_done_o     (di_done_o),
		.di_err_o      (di_err_o)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Watchdog on the whole run
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Run stopped after %0d cycles without reaching the end", cycles);
			$display("test failed");
			$finish;
		end
	end

	//////////////////////////////
	// Stim file
	//////////////////////////////

	// M lines load memory, T lines describe one test
	task automatic read_stim(output bit ok);
		int                fd;
		int                code;
		int                bad;
		logic [8*128-1:0]  text_line;
		logic [NAME_W-1:0] tag;
		logic [NAME_W-1:0] name;
		logic [7:0]        kind;
		logic [31:0]       f_a;
		logic [31:0]       f_b;
		logic [31:0]       f_c;
		logic [31:0]       f_d;
		logic [2:0]        f_flags;
		logic              f_err;
		ok  = 1'b0;
		bad = 0;
		fd  = $fopen("pkt_check_stim.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file pkt_check_stim.txt");
		end else begin
			while (!$feof(fd)) begin
				text_line = '0;
				tag       = '0;
				code      = $fgets(text_line, fd);
				if (code > 0)
					code = $sscanf(text_line, "%s", tag);
				// Comment and blank lines fall through
				if (code > 0 && tag == "M") begin
					code = $sscanf(text_line, "%s %h %h", tag, f_a, f_b);
					if (code != 3 || n_loads >= MAX_REC) begin
						bad++;
					end else begin
						load_addr[n_loads] = addr_t'(f_a);
						load_data[n_loads] = f_b;
						n_loads++;
					end
				end else if (code > 0 && tag == "T") begin
					code = $sscanf(text_line, "%s %s %s %h %h %h %h %b %b",
						tag, name, kind, f_a, f_b, f_c, f_d, f_flags, f_err);
					if (code != 9 || n_tests >= MAX_REC ||
						!(kind == "P" || kind == "D" || kind == "B")) begin
						bad++;
					end else begin
						t_name[n_tests]      = name;
						t_kind[n_tests]      = kind;
						t_paddr[n_tests]     = addr_t'(f_a);
						t_din[n_tests]       = addr_t'(f_b);
						t_dout[n_tests]      = addr_t'(f_c);
						t_cnt[n_tests]       = cnt_t'(f_d);
						t_exp_parse[n_tests] = parse_res_t'(f_flags);
						t_exp_di[n_tests]    = f_err;
						n_tests++;
					end
				end
			end
			$fclose(fd);
			if (bad > 0)
				$display("Stimulus file has %0d malformed records", bad);
			if (n_tests == 0)
				$display("Stimulus file holds no test records");
			ok = (bad == 0) && (n_tests > 0);
		end
	endtask

	//////////////////////////////
	// Drivers and compares
	//////////////////////////////

	// Load port, one word per cycle, checkers idle
	task automatic load_memory();
		for (int i = 0; i < n_loads; i++) begin
			@(posedge clk);
			mem_we_i    <= 1'b1;
			mem_addr_i  <= load_addr[i];
			mem_wdata_i <= load_data[i];
		end
		@(posedge clk);
		mem_we_i <= 1'b0;
	endtask

	task automatic check_parse(input logic [NAME_W-1:0] name, input parse_res_t exp,
		input parse_res_t act);
		if (act !== exp) begin
			$display("ERROR %0s: parse flags corr/uncorr/crc expected %b actual %b",
				name, exp, act);
			test_err = 1'b1;
		end
	endtask

	task automatic check_di(input logic [NAME_W-1:0] name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERROR %0s: di_err expected %b actual %b", name, exp, act);
			test_err = 1'b1;
		end
	endtask

	// One test, parse and data-integrity starts share a cycle
	task automatic run_test(input int i);
		bit   do_parse;
		bit   do_di;
		bit   parse_seen;
		bit   di_seen;
		int   waited;
		do_parse   = (t_kind[i] == "P") || (t_kind[i] == "B");
		do_di      = (t_kind[i] == "D") || (t_kind[i] == "B");
		parse_seen = !do_parse;
		di_seen    = !do_di;
		waited     = 0;
		test_err   = 1'b0;
		@(posedge clk);
		parse_addr_i  <= t_paddr[i];
		di_addr_in_i  <= t_din[i];
		di_addr_out_i <= t_dout[i];
		di_byte_cnt_i <= t_cnt[i];
		parse_start_i <= do_parse;
		di_start_i    <= do_di;
		@(posedge clk);
		parse_start_i <= 1'b0;
		di_start_i    <= 1'b0;
		// Done pulses may come in any order, sampled mid-cycle
		while (!(parse_seen && di_seen) && waited < TEST_CYCLES) begin
			@(negedge clk);
			waited++;
			if (!parse_seen && parse_done_o) begin
				parse_seen = 1'b1;
				check_parse(t_name[i], t_exp_parse[i], {ecc_corr_o, ecc_uncorr_o, crc_err_o});
			end
			if (!di_seen && di_done_o) begin
				di_seen = 1'b1;
				check_di(t_name[i], t_exp_di[i], di_err_o);
			end
		end
		if (!parse_seen) begin
			$display("%0s: parse check gave no done pulse within %0d cycles",
				t_name[i], TEST_CYCLES);
			test_err = 1'b1;
		end
		if (!di_seen) begin
			$display("%0s: data-integrity check gave no done pulse within %0d cycles",
				t_name[i], TEST_CYCLES);
			test_err = 1'b1;
		end
		if (test_err) begin
			n_fail++;
			$display("FAIL %0s", t_name[i]);
		end else begin
			n_pass++;
			$display("PASS %0s", t_name[i]);
		end
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		bit stim_ok;
		reset         = 1'b1;
		mem_we_i      = 1'b0;
		mem_addr_i    = '0;
		mem_wdata_i   = '0;
		parse_start_i = 1'b0;
		parse_addr_i  = '0;
		di_start_i    = 1'b0;
		di_addr_in_i  = '0;
		di_addr_out_i = '0;
		di_byte_cnt_i = '0;
		n_loads       = 0;
		n_tests       = 0;
		n_pass        = 0;
		n_fail        = 0;
		read_stim(stim_ok);
		// Reset, memory load, then every test at its worst case
		if (stim_ok)
			cycle_limit = RST_CYCLES + n_loads + 1 + n_tests * TEST_CYCLES;
		repeat (RST_CYCLES) @(posedge clk);
		reset <= 1'b0;
		if (!stim_ok) begin
			$display("No tests run, the stimulus file could not be used");
			n_fail++;
		end else begin
			load_memory();
			for (int i = 0; i < n_tests; i++)
				run_test(i);
		end
		$display("Tests passed %0d, failed %0d", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- pkt_check_stim.txt
# M addr data: write one memory word, both hex
# T name kind(P parse, D di, B both) parse_addr di_in di_out di_cnt (hex) flags corr,uncorr,crc (bin) di_err
M 00 BEEF012C
M 02 A5A5A501
M 03 A5A5A502
M 04 0000001B
M 08 0000112D
M 0A 00000001
M 0B 00000002
M 0C 0000001B
M 10 0000012D
M 12 00000001
M 13 00000002
M 14 0000001B
M 18 0000012C
M 1A 00000001
M 1B 00000002
M 1C 0000001A
M 20 0000020A
M 22 00000000
M 28 00000001
M 29 00000002
M 2E 5A5A5A01
M 2F 00000007
T clean_pkt P 00 00 00 0 000 0
T ecc_corr P 08 00 00 0 100 0
T ecc_uncorr P 10 00 00 0 010 0
T crc_bad P 18 00 00 0 001 0
T empty_pkt P 20 00 00 0 000 0
T di_match D 00 28 00 2 000 0
T di_mismatch D 00 28 2C 2 000 1
T di_zero D 00 28 00 0 000 0
T both_clean B 00 28 00 2 000 0
T both_err B 08 28 2C 2 100 1

//--- verilog.f
pkt_fmt_pkg.sv
chk_cfg_pkg.sv
mem_rd_if.sv
pkt_mem.sv
mem_arbiter.sv
parse_checker.sv
di_checker.sv
pkt_check_top.sv
tb_pkt_check.sv

//--- Bender.yml
package:
  name: pkt_check

sources:
  - pkt_fmt_pkg.sv
  - chk_cfg_pkg.sv
  - mem_rd_if.sv
  - pkt_mem.sv
  - mem_arbiter.sv
  - parse_checker.sv
  - di_checker.sv
  - pkt_check_top.sv
  - target: simulation
    files:
      - tb_pkt_check.sv
